/* common/rk8e_params.svh */
// shared constants for the RK8-E controller; bit numbers follow the PDP-8 order (bit 0 is MSB)
// read-all and write-all function codes are not handled

`ifndef RK8E_PARAMS_SVH
`define RK8E_PARAMS_SVH

`define RK8E_IOT_DSKP 12'o6741 // skip on done or error
`define RK8E_IOT_DCLR 12'o6742
`define RK8E_IOT_DLAG 12'o6743 // load disk address and go
`define RK8E_IOT_DLCA 12'o6744
`define RK8E_IOT_DRST 12'o6745
`define RK8E_IOT_DLDC 12'o6746
`define RK8E_IOT_CAF  12'o6007 // clear all flags, processor IOT

`define RK8E_BLOCK_WORDS 256
`define RK8E_HALF_WORDS  128

`define RK8E_ST_DONE  0
`define RK8E_ST_WLOCK 1 // write to a locked drive
`define RK8E_ST_BUSY  2 // go issued while busy

`define RK8E_CMD_FUNC  0:2
`define RK8E_CMD_IE    3
`define RK8E_CMD_HALF  5
`define RK8E_CMD_FIELD 6:8 // stored only
`define RK8E_CMD_DRIVE 9:10
`define RK8E_CMD_CYL   11

`define RK8E_FN_READ  3'd0
`define RK8E_FN_WLOCK 3'd2
`define RK8E_FN_SEEK  3'd3
`define RK8E_FN_WRITE 3'd4

`endif

/* common/pdp8_bus_pkg.sv */
// processor side types; words use the PDP-8 bit order with bit 0 as MSB
// the major state list covers the states the CPU can present

package pdp8_bus_pkg;

    typedef logic [0:11] word_t;

    // cpu major states, one cycle each
    typedef enum logic [4:0]
    {
        F0,
        F1,
        F2,
        F3,
        D0,
        D1,
        D2,
        D3,
        E0,
        E1,
        E2,
        E3,
        H0,
        H1,
        H2,
        H3
    } major_state_e;

    // data break request toward memory
    typedef struct packed
    {
        logic  write; // 1 writes memory
        word_t addr;
        word_t data;  // ignored on read breaks
    } db_req_t;

endpackage

/* common/rk8e_pkg.sv */
// controller side types; command field positions come from the params header
// storage block address is cylinder MSB followed by the 12-bit disk address

package rk8e_pkg;

    typedef logic [2:0]  func_t;  // command function code
    typedef logic [1:0]  drive_t; // one of four packs
    typedef logic [12:0] block_t; // block number within a pack
    typedef logic [8:0]  count_t; // word count up to a full block

    typedef logic [0:11] cmd_word_t;

    // registered IOT strobe, at most one flag set
    typedef struct packed
    {
        logic                dskp;
        logic                dclr;
        logic                dlag;
        logic                dlca;
        logic                drst;
        logic                dldc;
        logic                caf;
        pdp8_bus_pkg::word_t operand; // AC sampled in F1
    } iot_strobe_t;

    // request toward the sector store
    typedef struct packed
    {
        logic   write;
        drive_t drive;
        block_t block;
    } store_req_t;

    // block transfer sequencer
    typedef enum logic [2:0]
    {
        XFER_IDLE,
        XFER_START,
        XFER_READ_WORDS,
        XFER_WRITE_FETCH,
        XFER_WRITE_PAD,
        XFER_FINISH
    } xfer_state_e;

endpackage

/* rk8e/rk8e_iot_decode.sv */
// samples IOTs in F1 and registers a one-hot strobe with the AC
// unknown 674x codes such as 6747 give no strobe

`timescale 1ns/1ns

`include "rk8e_params.svh"

module rk8e_iot_decode
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  pdp8_bus_pkg::word_t       instruction,
    input  pdp8_bus_pkg::major_state_e state,
    input  pdp8_bus_pkg::word_t       ac,
    output rk8e_pkg::iot_strobe_t     iot,
    output logic                      iot_valid
);
    import pdp8_bus_pkg::*;
    import rk8e_pkg::*;

    iot_strobe_t iot_d;
    logic        hit;

    always_comb
    begin
        iot_d = '0;
        iot_d.operand = ac;
        if (state == F1) // IOT executes in F1 only
        begin
            case (instruction)
                `RK8E_IOT_DSKP: iot_d.dskp = 1'b1;
                `RK8E_IOT_DCLR: iot_d.dclr = 1'b1;
                `RK8E_IOT_DLAG: iot_d.dlag = 1'b1;
                `RK8E_IOT_DLCA: iot_d.dlca = 1'b1;
                `RK8E_IOT_DRST: iot_d.drst = 1'b1;
                `RK8E_IOT_DLDC: iot_d.dldc = 1'b1;
                `RK8E_IOT_CAF:  iot_d.caf  = 1'b1;
                default: ;
            endcase
        end
    end

    assign hit = iot_d.dskp | iot_d.dclr | iot_d.dlag | iot_d.dlca |
                 iot_d.drst | iot_d.dldc | iot_d.caf;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            iot       <= '0;
            iot_valid <= 1'b0;
        end
        else
        begin
            iot_valid <= hit;
            iot       <= iot_d; // operand follows AC every cycle
        end
    end

endmodule

/* rk8e/rk8e_transfer_ctrl.sv */
// register file, write locks and block sequencer; memory and store accept every strobe
// a read always consumes a full block from the store, half reads drop the tail

`timescale 1ns/1ns

`include "rk8e_params.svh"

module rk8e_transfer_ctrl
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  rk8e_pkg::iot_strobe_t iot,
    input  logic                  iot_valid,
    input  pdp8_bus_pkg::word_t   db_rdata,
    input  logic                  db_rdata_valid,
    input  pdp8_bus_pkg::word_t   store_rdata,
    input  logic                  store_rdata_valid,
    output pdp8_bus_pkg::db_req_t db_req,
    output logic                  db_req_valid,
    output rk8e_pkg::store_req_t  store_req,
    output logic                  store_req_valid,
    output pdp8_bus_pkg::word_t   store_wdata,
    output logic                  store_wdata_valid,
    output pdp8_bus_pkg::word_t   status,
    output logic                  done_or_error,
    output logic                  ie
);
    import pdp8_bus_pkg::*;
    import rk8e_pkg::*;

    cmd_word_t   cmd;
    word_t       car;        // current memory address
    word_t       dar;        // disk address
    logic [3:0]  wlock;      // one lock per drive
    xfer_state_e xstate;
    count_t      count;
    count_t      word_limit;
    logic        need_break; // next memory read pending
    func_t       func;
    drive_t      drive;
    logic        busy;
    logic        last_block_word;
    logic        last_data_word;

    assign func  = cmd[`RK8E_CMD_FUNC];
    assign drive = cmd[`RK8E_CMD_DRIVE];
    assign ie    = cmd[`RK8E_CMD_IE];
    assign busy  = (xstate != XFER_IDLE);

    assign word_limit = cmd[`RK8E_CMD_HALF] ? count_t'(`RK8E_HALF_WORDS)
                                            : count_t'(`RK8E_BLOCK_WORDS);
    assign last_block_word = (count == count_t'(`RK8E_BLOCK_WORDS - 1));
    assign last_data_word  = (count == word_limit - 1'b1);

    assign done_or_error = status[`RK8E_ST_DONE] | status[`RK8E_ST_WLOCK] |
                           status[`RK8E_ST_BUSY];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cmd               <= '0;
            car               <= '0;
            dar               <= '0;
            status            <= '0;
            wlock             <= '0;
            xstate            <= XFER_IDLE;
            count             <= '0;
            need_break        <= 1'b0;
            db_req            <= '0;
            db_req_valid      <= 1'b0;
            store_req         <= '0;
            store_req_valid   <= 1'b0;
            store_wdata       <= '0;
            store_wdata_valid <= 1'b0;
        end
        else
        begin
            db_req_valid      <= 1'b0;
            store_req_valid   <= 1'b0;
            store_wdata_valid <= 1'b0;

            case (xstate)
                XFER_START:
                begin
                    store_req_valid <= 1'b1;
                    store_req.write <= (func == `RK8E_FN_WRITE);
                    store_req.drive <= drive;
                    store_req.block <= {cmd[`RK8E_CMD_CYL], dar};
                    count           <= '0;
                    need_break      <= 1'b1;
                    xstate          <= (func == `RK8E_FN_WRITE) ? XFER_WRITE_FETCH
                                                                : XFER_READ_WORDS;
                end
                XFER_READ_WORDS:
                begin
                    if (store_rdata_valid)
                    begin
                        if (count < word_limit)
                        begin
                            db_req_valid <= 1'b1;
                            db_req.write <= 1'b1;
                            db_req.addr  <= car;
                            db_req.data  <= store_rdata;
                            car          <= car + 1'b1;
                        end
                        count <= count + 1'b1;
                        if (last_block_word)
                            xstate <= XFER_FINISH;
                    end
                end
                XFER_WRITE_FETCH:
                begin
                    if (need_break)
                    begin
                        db_req_valid <= 1'b1;
                        db_req.write <= 1'b0;
                        db_req.addr  <= car;
                        db_req.data  <= '0;
                        car          <= car + 1'b1;
                        need_break   <= 1'b0;
                    end
                    else if (db_rdata_valid)
                    begin
                        store_wdata_valid <= 1'b1;
                        store_wdata       <= db_rdata;
                        count             <= count + 1'b1;
                        if (!last_data_word)
                            need_break <= 1'b1;
                        else if (last_block_word)
                            xstate <= XFER_FINISH;
                        else
                            xstate <= XFER_WRITE_PAD; // half block tail
                    end
                end
                XFER_WRITE_PAD:
                begin
                    store_wdata_valid <= 1'b1;
                    store_wdata       <= '0;
                    count             <= count + 1'b1;
                    if (last_block_word)
                        xstate <= XFER_FINISH;
                end
                XFER_FINISH:
                begin
                    status[`RK8E_ST_DONE] <= 1'b1;
                    xstate                <= XFER_IDLE;
                end
                default: ;
            endcase

            // IOTs take priority over the sequencer
            if (iot_valid)
            begin
                if (iot.caf || (iot.dclr && iot.operand[10]))
                begin
                    status <= '0;
                    cmd    <= '0;
                    car    <= '0;
                    dar    <= '0;
                    xstate <= XFER_IDLE; // abort any transfer
                end
                else if (iot.dclr && iot.operand[11])
                    status <= '0;
                else if (iot.dldc)
                begin
                    cmd    <= iot.operand;
                    status <= '0;
                end
                else if (iot.dlca)
                    car <= iot.operand;
                else if (iot.dlag)
                begin
                    if (busy)
                        status[`RK8E_ST_BUSY] <= 1'b1;
                    else
                    begin
                        dar <= iot.operand;
                        case (func)
                            `RK8E_FN_READ:
                                xstate <= XFER_START;
                            `RK8E_FN_WRITE:
                            begin
                                if (wlock[drive])
                                begin
                                    status[`RK8E_ST_WLOCK] <= 1'b1;
                                    status[`RK8E_ST_DONE]  <= 1'b1;
                                end
                                else
                                    xstate <= XFER_START;
                            end
                            `RK8E_FN_WLOCK:
                            begin
                                wlock[drive]          <= 1'b1;
                                status[`RK8E_ST_DONE] <= 1'b1;
                            end
                            default:
                                status[`RK8E_ST_DONE] <= 1'b1; // seek completes at once
                        endcase
                    end
                end
            end
        end
    end

endmodule

/* rk8e/rk8e_cpu_return.sv */
// skip, disk bus and interrupt toward the CPU; skip is masked during F0
// disk_bus holds the last DRST value until the next DRST

`timescale 1ns/1ns

module rk8e_cpu_return
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  pdp8_bus_pkg::major_state_e state,
    input  rk8e_pkg::iot_strobe_t      iot,
    input  logic                       iot_valid,
    input  pdp8_bus_pkg::word_t        status,
    input  logic                       done_or_error,
    input  logic                       ie,
    output logic                       skip,
    output pdp8_bus_pkg::word_t        disk_bus,
    output logic                       interrupt
);
    import pdp8_bus_pkg::*;

    logic skip_q;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            skip_q    <= 1'b0;
            disk_bus  <= '0;
            interrupt <= 1'b0;
        end
        else
        begin
            interrupt <= done_or_error & ie; // level, one cycle behind

            if (state == F0)
                skip_q <= 1'b0; // new instruction
            else if (iot_valid && iot.dskp && done_or_error)
                skip_q <= 1'b1;

            if (iot_valid && iot.drst)
                disk_bus <= status;
        end
    end

    // CPU may still be in F0 when the register clears
    assign skip = skip_q && (state != F0);

endmodule

/* design/rk8e_top.sv */
// RK8-E controller top; sector store and memory are modelled as always ready
// extended memory field bits are stored and otherwise ignored

`timescale 1ns/1ns

module rk8e_top
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  pdp8_bus_pkg::word_t        instruction,
    input  pdp8_bus_pkg::major_state_e state,
    input  pdp8_bus_pkg::word_t        ac,
    input  pdp8_bus_pkg::word_t        db_rdata,
    input  logic                       db_rdata_valid,
    input  pdp8_bus_pkg::word_t        store_rdata,
    input  logic                       store_rdata_valid,
    output pdp8_bus_pkg::word_t        disk_bus,
    output logic                       skip,
    output logic                       interrupt,
    output pdp8_bus_pkg::db_req_t      db_req,
    output logic                       db_req_valid,
    output rk8e_pkg::store_req_t       store_req,
    output logic                       store_req_valid,
    output pdp8_bus_pkg::word_t        store_wdata,
    output logic                       store_wdata_valid
);
    import pdp8_bus_pkg::*;
    import rk8e_pkg::*;

    iot_strobe_t iot;
    logic        iot_valid;
    word_t       status;
    logic        done_or_error;
    logic        ie;

    rk8e_iot_decode i_rk8e_iot_decode
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .instruction (instruction),
        .state       (state),
        .ac          (ac),
        .iot         (iot),
        .iot_valid   (iot_valid)
    );

    rk8e_transfer_ctrl i_rk8e_transfer_ctrl
    (
        .clk               (clk),
        .arst_n            (arst_n),
        .iot               (iot),
        .iot_valid         (iot_valid),
        .db_rdata          (db_rdata),
        .db_rdata_valid    (db_rdata_valid),
        .store_rdata       (store_rdata),
        .store_rdata_valid (store_rdata_valid),
        .db_req            (db_req),
        .db_req_valid      (db_req_valid),
        .store_req         (store_req),
        .store_req_valid   (store_req_valid),
        .store_wdata       (store_wdata),
        .store_wdata_valid (store_wdata_valid),
        .status            (status),
        .done_or_error     (done_or_error),
        .ie                (ie)
    );

    rk8e_cpu_return i_rk8e_cpu_return
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .state         (state),
        .iot           (iot),
        .iot_valid     (iot_valid),
        .status        (status),
        .done_or_error (done_or_error),
        .ie            (ie),
        .skip          (skip),
        .disk_bus      (disk_bus),
        .interrupt     (interrupt)
    );

endmodule

/* tb/rk8e_assert.sv */
// protocol assertions on the controller top level
// the write data window assumes done is clear when a write transfer starts

`timescale 1ns/1ns

`include "rk8e_params.svh"

module rk8e_assert
(
    input logic                       clk,
    input logic                       arst_n,
    input pdp8_bus_pkg::major_state_e state,
    input logic                       skip,
    input logic                       db_req_valid,
    input logic                       store_wdata_valid,
    input rk8e_pkg::store_req_t       store_req,
    input logic                       store_req_valid,
    input pdp8_bus_pkg::word_t        status
);
    import pdp8_bus_pkg::*;

    int   fail_count = 0;
    logic write_open; // write request seen and done not yet risen
    logic done_q;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            write_open <= 1'b0;
            done_q     <= 1'b0;
        end
        else
        begin
            done_q <= status[`RK8E_ST_DONE];
            if (store_req_valid && store_req.write)
                write_open <= 1'b1;
            else if (status[`RK8E_ST_DONE] && !done_q)
                write_open <= 1'b0; // done rising edge
        end
    end

    skip_clear_after_f0: assert property (@(posedge clk) disable iff (!arst_n)
        (state == F0) |=> !skip)
    else
    begin
        fail_count++;
        $error("skip still high in the cycle after F0");
    end

    one_strobe_per_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        !(db_req_valid && store_wdata_valid))
    else
    begin
        fail_count++;
        $error("data break and store write data in the same cycle");
    end

    wdata_in_write_window: assert property (@(posedge clk) disable iff (!arst_n)
        store_wdata_valid |-> write_open)
    else
    begin
        fail_count++;
        $error("store write data outside a write transfer");
    end

endmodule

/* tb/tb_rk8e.sv */
// directed testbench with a 4096-word memory model and a four-pack sector store model
// model response delays come from a fixed seed; store packs are generated from the address

`timescale 1ns/1ns

`include "rk8e_params.svh"

module tb_rk8e;
    import pdp8_bus_pkg::*;
    import rk8e_pkg::*;

    localparam word_t ST_DONE  = 12'o4000; // status bit 0
    localparam word_t ST_WLOCK = 12'o2000; // status bit 1
    localparam word_t ST_BUSY  = 12'o1000; // status bit 2
    localparam word_t NOP      = 12'o7000;

    logic         clk;
    logic         arst_n;
    word_t        instruction;
    major_state_e state;
    word_t        ac;
    word_t        db_rdata;
    logic         db_rdata_valid;
    word_t        store_rdata;
    logic         store_rdata_valid;
    word_t        disk_bus;
    logic         skip;
    logic         interrupt;
    db_req_t      db_req;
    logic         db_req_valid;
    store_req_t   store_req;
    logic         store_req_valid;
    word_t        store_wdata;
    logic         store_wdata_valid;

    word_t        mem [0:4095];
    word_t        mem_wr_addr_q[$];
    word_t        mem_wr_data_q[$];
    word_t        mem_rd_addr_q[$];
    word_t        store_wr_q[$];
    store_req_t   store_req_q[$];
    store_req_t   read_req;
    logic         read_pending = 1'b0;
    int           errors = 0;

    rk8e_top i_rk8e_top
    (
        .clk               (clk),
        .arst_n            (arst_n),
        .instruction       (instruction),
        .state             (state),
        .ac                (ac),
        .db_rdata          (db_rdata),
        .db_rdata_valid    (db_rdata_valid),
        .store_rdata       (store_rdata),
        .store_rdata_valid (store_rdata_valid),
        .disk_bus          (disk_bus),
        .skip              (skip),
        .interrupt         (interrupt),
        .db_req            (db_req),
        .db_req_valid      (db_req_valid),
        .store_req         (store_req),
        .store_req_valid   (store_req_valid),
        .store_wdata       (store_wdata),
        .store_wdata_valid (store_wdata_valid)
    );

    bind rk8e_top rk8e_assert i_rk8e_assert
    (
        .clk               (clk),
        .arst_n            (arst_n),
        .state             (state),
        .skip              (skip),
        .db_req_valid      (db_req_valid),
        .store_wdata_valid (store_wdata_valid),
        .store_req         (store_req),
        .store_req_valid   (store_req_valid),
        .status            (status)
    );

    always #20 clk = ~clk;

    function automatic word_t mem_fill(input logic [11:0] a);
        return word_t'(a ^ {a[5:0], a[11:6]} ^ 12'o2525);
    endfunction

    // pack contents as a function of drive, block and word
    function automatic word_t store_word(input logic [1:0] drive, input logic [12:0] block,
                                         input int idx);
        logic [22:0] addr;
        begin
            addr = {drive, block, idx[7:0]};
            return word_t'(addr[11:0] ^ {1'b0, addr[22:12]} ^ 12'o1234);
        end
    endfunction

    // command word in PDP-8 bit order with bit 0 as MSB
    function automatic word_t make_cmd(input logic [2:0] func, input logic ie,
                                       input logic half, input logic [1:0] drive,
                                       input logic cyl);
        word_t c;
        begin
            c = '0;
            c[0:2]  = func;
            c[3]    = ie;
            c[5]    = half;
            c[9:10] = drive;
            c[11]   = cyl;
            return c;
        end
    endfunction

    task automatic serve_memory();
        int    delay;
        word_t rd_addr;
        forever
        begin
            @(negedge clk);
            if (db_req_valid)
            begin
                if (db_req.write)
                begin
                    mem[db_req.addr] = db_req.data;
                    mem_wr_addr_q.push_back(db_req.addr);
                    mem_wr_data_q.push_back(db_req.data);
                end
                else
                begin
                    rd_addr = db_req.addr;
                    mem_rd_addr_q.push_back(rd_addr);
                    delay = $urandom_range(3, 0);
                    @(posedge clk);
                    repeat (delay) @(posedge clk);
                    #2;
                    db_rdata       = mem[rd_addr];
                    db_rdata_valid = 1'b1;
                    @(posedge clk);
                    #2;
                    db_rdata_valid = 1'b0;
                end
            end
        end
    endtask

    always @(negedge clk)
    begin
        if (store_req_valid)
        begin
            store_req_q.push_back(store_req);
            if (!store_req.write)
            begin
                read_req     = store_req;
                read_pending = 1'b1;
            end
        end
        if (store_wdata_valid)
            store_wr_q.push_back(store_wdata);
    end

    task automatic serve_store_reads();
        int gap;
        forever
        begin
            @(posedge clk);
            if (read_pending)
            begin
                read_pending = 1'b0;
                for (int i = 0; i < 256; i++)
                begin
                    gap = $urandom_range(3, 0);
                    repeat (gap)
                    begin
                        @(posedge clk);
                        #2;
                        store_rdata_valid = 1'b0;
                    end
                    @(posedge clk);
                    #2;
                    store_rdata       = store_word(read_req.drive, read_req.block, i);
                    store_rdata_valid = 1'b1;
                end
                @(posedge clk);
                #2;
                store_rdata_valid = 1'b0;
            end
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_block(input string name, input block_t got, input block_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // drives F0 then F1 with the IOT and returns at the negedge after the results settle
    task automatic issue_iot(input word_t code, input word_t operand);
        @(posedge clk);
        #2;
        state       = F0;
        instruction = NOP;
        ac          = '0;
        @(posedge clk);
        #2;
        state       = F1;
        instruction = code;
        ac          = operand;
        @(posedge clk);
        #2;
        state       = F2;
        instruction = NOP;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic wait_done(input int max_polls);
        int   polls;
        logic seen;
        begin
            polls = 0;
            seen  = 1'b0;
            while (!seen && polls < max_polls)
            begin
                issue_iot(`RK8E_IOT_DSKP, '0);
                seen = skip;
                polls++;
            end
            if (!seen)
            begin
                $display("timeout: no skip on done after %0d DSKP polls", polls);
                errors++;
            end
        end
    endtask

    task automatic clear_logs();
        mem_wr_addr_q.delete();
        mem_wr_data_q.delete();
        mem_rd_addr_q.delete();
        store_wr_q.delete();
        store_req_q.delete();
    endtask

    task automatic register_access();
        issue_iot(`RK8E_IOT_CAF, '0);
        issue_iot(`RK8E_IOT_DLDC, make_cmd(3'd3, 1'b0, 1'b0, 2'd0, 1'b0));
        issue_iot(`RK8E_IOT_DRST, '0);
        check_word("disk_bus", disk_bus, '0);
        issue_iot(`RK8E_IOT_DSKP, '0);
        check_word("skip", word_t'(skip), '0);
        issue_iot(`RK8E_IOT_DLAG, 12'o0017); // seek finishes at once
        issue_iot(`RK8E_IOT_DSKP, '0);
        check_word("skip", word_t'(skip), 12'o0001);
        issue_iot(`RK8E_IOT_DRST, '0);
        check_word("disk_bus", disk_bus, ST_DONE);
    endtask

    task automatic full_block_read();
        word_t exp_addr;
        begin
            issue_iot(`RK8E_IOT_CAF, '0);
            clear_logs();
            issue_iot(`RK8E_IOT_DLDC, make_cmd(3'd0, 1'b1, 1'b0, 2'd1, 1'b1));
            issue_iot(`RK8E_IOT_DLCA, 12'o1200);
            issue_iot(`RK8E_IOT_DLAG, 12'o0345);
            wait_done(2000);
            if (store_req_q.size() != 1)
            begin
                $display("read: %0d store requests seen, expected one", store_req_q.size());
                errors++;
            end
            else
            begin
                check_word("store_req.write", word_t'(store_req_q[0].write), '0);
                check_word("store_req.drive", word_t'(store_req_q[0].drive), 12'o0001);
                check_block("store_req.block", store_req_q[0].block, {1'b1, 12'o0345});
            end
            if (mem_wr_addr_q.size() != 256)
            begin
                $display("read: %0d memory writes seen, expected 256", mem_wr_addr_q.size());
                errors++;
            end
            else
            begin
                for (int i = 0; i < 256; i++)
                begin
                    exp_addr = 12'o1200 + i;
                    check_word("db_req.addr", mem_wr_addr_q[i], exp_addr);
                    check_word("db_req.data", mem_wr_data_q[i],
                               store_word(2'd1, {1'b1, 12'o0345}, i));
                end
            end
            issue_iot(`RK8E_IOT_DRST, '0);
            check_word("disk_bus", disk_bus, ST_DONE);
            check_word("interrupt", word_t'(interrupt), 12'o0001);
        end
    endtask

    task automatic half_block_write();
        word_t exp_addr;
        begin
            issue_iot(`RK8E_IOT_CAF, '0);
            clear_logs();
            issue_iot(`RK8E_IOT_DLDC, make_cmd(3'd4, 1'b0, 1'b1, 2'd0, 1'b0));
            issue_iot(`RK8E_IOT_DLCA, 12'o2000);
            issue_iot(`RK8E_IOT_DLAG, 12'o0012);
            wait_done(2000);
            if (store_req_q.size() != 1)
            begin
                $display("write: %0d store requests seen, expected one", store_req_q.size());
                errors++;
            end
            else
            begin
                check_word("store_req.write", word_t'(store_req_q[0].write), 12'o0001);
                check_word("store_req.drive", word_t'(store_req_q[0].drive), '0);
                check_block("store_req.block", store_req_q[0].block, {1'b0, 12'o0012});
            end
            if (mem_rd_addr_q.size() != 128 || store_wr_q.size() != 256)
            begin
                $display("write: %0d memory reads and %0d store words, expected 128 and 256",
                         mem_rd_addr_q.size(), store_wr_q.size());
                errors++;
            end
            else
            begin
                for (int i = 0; i < 256; i++)
                begin
                    exp_addr = 12'o2000 + i;
                    if (i < 128)
                    begin
                        check_word("db_req.addr", mem_rd_addr_q[i], exp_addr);
                        check_word("store_wdata", store_wr_q[i], mem_fill(exp_addr));
                    end
                    else
                        check_word("store_wdata", store_wr_q[i], '0); // pad words
                end
            end
            check_word("interrupt", word_t'(interrupt), '0);
        end
    endtask

    task automatic write_lock();
        issue_iot(`RK8E_IOT_CAF, '0);
        clear_logs();
        issue_iot(`RK8E_IOT_DLDC, make_cmd(3'd2, 1'b0, 1'b0, 2'd2, 1'b0));
        issue_iot(`RK8E_IOT_DLAG, '0);
        issue_iot(`RK8E_IOT_DRST, '0);
        check_word("disk_bus", disk_bus, ST_DONE);
        issue_iot(`RK8E_IOT_DLDC, make_cmd(3'd4, 1'b0, 1'b0, 2'd2, 1'b0));
        issue_iot(`RK8E_IOT_DLAG, 12'o0100);
        issue_iot(`RK8E_IOT_DRST, '0);
        check_word("disk_bus", disk_bus, ST_DONE | ST_WLOCK);
        issue_iot(`RK8E_IOT_DSKP, '0);
        check_word("skip", word_t'(skip), 12'o0001);
        if (store_req_q.size() != 0)
        begin
            $display("write lock: store request issued to a locked drive");
            errors++;
        end
    endtask

    task automatic clear_and_busy();
        issue_iot(`RK8E_IOT_CAF, '0);
        issue_iot(`RK8E_IOT_DLDC, make_cmd(3'd3, 1'b1, 1'b0, 2'd0, 1'b0));
        issue_iot(`RK8E_IOT_DLAG, '0);
        issue_iot(`RK8E_IOT_DSKP, '0);
        check_word("skip", word_t'(skip), 12'o0001);
        check_word("interrupt", word_t'(interrupt), 12'o0001);
        issue_iot(`RK8E_IOT_DCLR, 12'o0002); // AC bit 10
        issue_iot(`RK8E_IOT_DRST, '0);
        check_word("disk_bus", disk_bus, '0);
        check_word("interrupt", word_t'(interrupt), '0);
        issue_iot(`RK8E_IOT_DSKP, '0);
        check_word("skip", word_t'(skip), '0);

        issue_iot(`RK8E_IOT_DLDC, make_cmd(3'd3, 1'b1, 1'b0, 2'd0, 1'b0));
        issue_iot(`RK8E_IOT_DLAG, '0);
        issue_iot(`RK8E_IOT_CAF, '0);
        issue_iot(`RK8E_IOT_DSKP, '0);
        check_word("skip", word_t'(skip), '0);
        check_word("interrupt", word_t'(interrupt), '0);

        issue_iot(`RK8E_IOT_DLDC, make_cmd(3'd0, 1'b0, 1'b0, 2'd3, 1'b0));
        issue_iot(`RK8E_IOT_DLCA, 12'o3000);
        issue_iot(`RK8E_IOT_DLAG, 12'o0200);
        issue_iot(`RK8E_IOT_DLAG, 12'o0201); // second go while busy
        issue_iot(`RK8E_IOT_DRST, '0);
        check_word("disk_bus", disk_bus, ST_BUSY);
        issue_iot(`RK8E_IOT_CAF, '0);
        issue_iot(`RK8E_IOT_DRST, '0);
        check_word("disk_bus", disk_bus, '0);
    endtask

    initial
    begin
        void'($urandom(6587));
        clk               = 1'b0;
        arst_n            = 1'b0;
        instruction       = NOP;
        state             = F0;
        ac                = '0;
        db_rdata          = '0;
        db_rdata_valid    = 1'b0;
        store_rdata       = '0;
        store_rdata_valid = 1'b0;
        for (int a = 0; a < 4096; a++)
            mem[a] = mem_fill(a[11:0]);
        fork
            serve_memory();
            serve_store_reads();
        join_none
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;

        register_access();
        full_block_read();
        half_block_write();
        write_lock();
        clear_and_busy();

        errors += i_rk8e_top.i_rk8e_assert.fail_count;
        $display("errors: %0d (assertion failures: %0d)", errors,
                 i_rk8e_top.i_rk8e_assert.fail_count);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* rk8e.f */
+incdir+common
common/pdp8_bus_pkg.sv
common/rk8e_pkg.sv
rk8e/rk8e_iot_decode.sv
rk8e/rk8e_transfer_ctrl.sv
rk8e/rk8e_cpu_return.sv
design/rk8e_top.sv
tb/rk8e_assert.sv
tb/tb_rk8e.sv
